// ==== files.f ====
verilog/ari_pkg.sv
verilog/poll_pkg.sv
verilog/ari_port_if.sv
verilog/sync_fifo.sv
verilog/ari_ingress.sv
verilog/poll_grant.sv
verilog/poll_sender.sv
verilog/poll_mux4.sv
tests/tb_clk_gen.sv
tests/tb_poll_mux4.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
for p in 0 1; do
    verilator --binary --timing -f files.f --top-module tb_poll_mux4 -GPOLICY=$p \
        -Mdir obj_dir_p$p -o sim_p$p &&
    out=$(./obj_dir_p$p/sim_p$p) && echo "$out" &&
    echo "$out" | grep -qx "Test passed" || { echo "policy $p: FAIL"; exit 1; }
done
echo "both policies: PASS"

// ==== tests/tb_poll_mux4.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_poll_mux4 #(
    parameter int POLICY = 0                    // 0 round robin, 1 fixed priority
);

    localparam int NP         = poll_pkg::NUM_PORTS;
    localparam int FIFO_DEPTH = 16;
    localparam int ALF_LEVEL  = 8;
    localparam int TIMEOUT    = 500;            // cycles per wait
    localparam poll_pkg::poll_policy_e DUT_POLICY =
        (POLICY == 1) ? poll_pkg::POLICY_SP : poll_pkg::POLICY_RR;

    logic               clk;
    logic               rst_n;
    ari_pkg::ari_beat_t ari_data [NP];
    logic [NP-1:0]      ari_data_en;
    ari_pkg::ari_info_t ari_info [NP];
    logic [NP-1:0]      ari_info_en;
    wire  [NP-1:0]      fifo_alf_out;
    wire  ari_pkg::ari_beat_t out_data;
    wire                out_data_en;
    wire  ari_pkg::ari_info_t out_info;
    wire                out_info_en;
    logic               down_alf;               // downstream almost-full

    ari_pkg::ari_beat_t exp_beats [$];          // expected beats in output order
    ari_pkg::ari_info_t exp_infos [$];
    ari_pkg::ari_beat_t held_beats [$];         // frames expected later
    ari_pkg::ari_info_t held_infos [$];
    logic [31:0]        rng_state = 32'd46668;
    int                 err_count = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    logic               in_frame = 1'b0;
    logic               prev_tail = 1'b0;

    tb_clk_gen clk_gen_inst (
        .o_clk (clk)
    );

    poll_mux4 #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .ALF_LEVEL  (ALF_LEVEL),
        .POLICY     (DUT_POLICY)
    ) poll_mux4_inst (
        .i_sys_clk      (clk),
        .i_sys_rst_n    (rst_n),
        .i_ari_data     (ari_data),
        .i_ari_data_en  (ari_data_en),
        .i_ari_info     (ari_info),
        .i_ari_info_en  (ari_info_en),
        .o_ari_fifo_alf (fifo_alf_out),
        .o_ari_data     (out_data),
        .o_ari_data_en  (out_data_en),
        .o_ari_info     (out_info),
        .o_ari_info_en  (out_info_en),
        .i_ari_fifo_alf (down_alf)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [35:0] expected,
                                   input logic [35:0] actual);
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        err_count++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        err_count++;
    endtask

    // one output cycle against the expected beats and info words
    task automatic check_output_cycle();
        ari_pkg::ari_beat_t exp_beat;
        ari_pkg::ari_info_t exp_info;
        logic               is_tail;
        is_tail = (out_data.pos == ari_pkg::POS_TAIL) || (out_data.pos == ari_pkg::POS_SINGLE);
        if (in_frame && !out_data_en) report_error("frame interrupted before its tail beat");
        if (prev_tail && out_data_en) report_error("no idle cycle between two frames");
        if (out_data_en) begin
            if (exp_beats.size() == 0) begin
                report_error("beat on the output while none was expected");
            end else begin
                exp_beat = exp_beats.pop_front();
                if (out_data !== exp_beat) report_mismatch("o_ari_data", exp_beat, out_data);
            end
        end
        if (out_info_en !== (out_data_en && is_tail)) begin
            report_error("o_ari_info_en not aligned with the tail beat");
        end
        if (out_info_en) begin
            if (exp_infos.size() == 0) begin
                report_error("info word on the output while none was expected");
            end else begin
                exp_info = exp_infos.pop_front();
                if (out_info !== exp_info) begin
                    report_mismatch("o_ari_info", 36'(exp_info), 36'(out_info));
                end
            end
        end
        in_frame  = out_data_en && !is_tail;
        prev_tail = out_data_en && is_tail;
    endtask

    always @(negedge clk) begin
        if (rst_n) check_output_cycle();
    end

    // defer keeps the frame out of the scoreboard until release_held
    task automatic write_frame(input int port, input int nbeats, input bit defer);
        ari_pkg::ari_beat_t beat;
        ari_pkg::ari_info_t info;
        logic [31:0]        r;
        for (int i = 0; i < nbeats; i++) begin
            r = lcg_next();
            beat.payload     = lcg_next();
            beat.empty_bytes = (i == nbeats - 1) ? r[1:0] : 2'b00;
            if (nbeats == 1) beat.pos = ari_pkg::POS_SINGLE;
            else if (i == 0) beat.pos = ari_pkg::POS_HEAD;
            else if (i == nbeats - 1) beat.pos = ari_pkg::POS_TAIL;
            else beat.pos = ari_pkg::POS_BODY;
            @(negedge clk);
            ari_data[port]    = beat;
            ari_data_en[port] = 1'b1;
            if (defer) held_beats.push_back(beat);
            else exp_beats.push_back(beat);
            if (i == nbeats - 1) begin
                info.valid     = 1'b1;
                info.inport_bm = 4'(1 << port);
                info.pkt_len   = 11'(nbeats * 4 - int'(beat.empty_bytes));
                ari_info[port]    = info;
                ari_info_en[port] = 1'b1;   // info goes in with the tail
                if (defer) held_infos.push_back(info);
                else exp_infos.push_back(info);
            end
        end
        @(negedge clk);
        ari_data_en[port] = 1'b0;
        ari_info_en[port] = 1'b0;
    endtask

    task automatic release_held();
        while (held_beats.size() > 0) exp_beats.push_back(held_beats.pop_front());
        while (held_infos.size() > 0) exp_infos.push_back(held_infos.pop_front());
    endtask

    task automatic wait_pending(input int level);
        int n;
        n = 0;
        while (exp_beats.size() > level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_beats.size() > level) begin
            report_error($sformatf("timed out with %0d beats still expected", exp_beats.size()));
        end
        @(negedge clk);
    endtask

    task automatic wait_for_output();
        int n;
        n = 0;
        while (!out_data_en && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_data_en) report_error("timed out waiting for a frame on the output");
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (out_data_en) report_error("frame started while downstream almost-full was high");
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, err_count - errs_at_start);
        end
    endtask

    task automatic test_reset_state();
        int errs_at_start;
        errs_at_start = err_count;
        if (out_data_en !== 1'b0) report_mismatch("o_ari_data_en", 36'd0, 36'(out_data_en));
        if (out_info_en !== 1'b0) report_mismatch("o_ari_info_en", 36'd0, 36'(out_info_en));
        if (fifo_alf_out !== '0) report_mismatch("o_ari_fifo_alf", 36'd0, 36'(fifo_alf_out));
        if (out_data !== '0) report_mismatch("o_ari_data", 36'd0, out_data);
        if (out_info !== '0) report_mismatch("o_ari_info", 36'd0, 36'(out_info));
        finish_test("reset_state", errs_at_start);
    endtask

    task automatic test_single_frame();
        int errs_at_start;
        errs_at_start = err_count;
        write_frame(2, 3, 1'b0);
        wait_pending(0);
        finish_test("single_frame", errs_at_start);
    endtask

    // mask holds ports 0..2 after the previous test, so round robin starts at port 0
    task automatic test_arbitration_order();
        int errs_at_start;
        logic sp;
        errs_at_start = err_count;
        sp = (DUT_POLICY == poll_pkg::POLICY_SP);
        down_alf = 1'b1;
        write_frame(0, 2, 1'b0);
        write_frame(1, 3, sp);                  // last under fixed priority
        write_frame(0, 4, 1'b0);
        release_held();
        @(negedge clk);
        down_alf = 1'b0;
        wait_pending(0);
        finish_test("arbitration_order", errs_at_start);
    endtask

    task automatic test_back_pressure();
        int errs_at_start;
        errs_at_start = err_count;
        down_alf = 1'b1;
        write_frame(1, 5, 1'b0);
        write_frame(1, 2, 1'b0);
        expect_quiet(20);
        down_alf = 1'b0;
        wait_for_output();
        down_alf = 1'b1;                        // mid frame
        wait_pending(2);
        expect_quiet(20);
        down_alf = 1'b0;
        wait_pending(0);
        finish_test("back_pressure", errs_at_start);
    endtask

    task automatic test_port_alf();
        int errs_at_start;
        errs_at_start = err_count;
        down_alf = 1'b1;
        write_frame(3, 4, 1'b0);
        write_frame(3, ALF_LEVEL - 5, 1'b0);
        if (fifo_alf_out !== 4'b0000) report_mismatch("o_ari_fifo_alf", 36'd0, 36'(fifo_alf_out));
        write_frame(3, 1, 1'b0);                // reaches ALF_LEVEL beats
        if (fifo_alf_out !== 4'b1000) report_mismatch("o_ari_fifo_alf", 36'h8, 36'(fifo_alf_out));
        down_alf = 1'b0;
        wait_pending(0);
        if (fifo_alf_out !== 4'b0000) report_mismatch("o_ari_fifo_alf", 36'd0, 36'(fifo_alf_out));
        finish_test("port_alf", errs_at_start);
    endtask

    initial begin
        rst_n       = 1'b0;
        down_alf    = 1'b0;
        ari_data_en = '0;
        ari_info_en = '0;
        for (int i = 0; i < NP; i++) begin
            ari_data[i] = '0;
            ari_info[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_single_frame();
        test_arbitration_order();
        test_back_pressure();
        test_port_alf();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 5            // 10 ns period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== verilog/poll_mux4.sv ====
`timescale 1ns/1ps
`default_nettype none

module poll_mux4 #(
    parameter int                     FIFO_DEPTH = 16,
    parameter int                     ALF_LEVEL  = 8,
    parameter poll_pkg::poll_policy_e POLICY     = poll_pkg::POLICY_RR
) (
    input  wire                                 i_sys_clk,
    input  wire                                 i_sys_rst_n,
    input  wire ari_pkg::ari_beat_t             i_ari_data [poll_pkg::NUM_PORTS],
    input  wire [poll_pkg::NUM_PORTS-1:0]       i_ari_data_en,
    input  wire ari_pkg::ari_info_t             i_ari_info [poll_pkg::NUM_PORTS],
    input  wire [poll_pkg::NUM_PORTS-1:0]       i_ari_info_en,
    output wire [poll_pkg::NUM_PORTS-1:0]       o_ari_fifo_alf,
    output wire ari_pkg::ari_beat_t             o_ari_data,
    output wire                                 o_ari_data_en,
    output wire ari_pkg::ari_info_t             o_ari_info,
    output wire                                 o_ari_info_en,
    input  wire                                 i_ari_fifo_alf
);

    wire       grant_valid;                     // some port has a frame
    wire [1:0] grant_port;
    wire       take;                            // sender accepted the grant

    ari_port_if port_bus [poll_pkg::NUM_PORTS] ();

    for (genvar i = 0; i < poll_pkg::NUM_PORTS; i++) begin : g_ingress
        ari_ingress #(
            .FIFO_DEPTH (FIFO_DEPTH),
            .ALF_LEVEL  (ALF_LEVEL)
        ) ari_ingress_inst (
            .i_sys_clk   (i_sys_clk),
            .i_sys_rst_n (i_sys_rst_n),
            .i_data      (i_ari_data[i]),
            .i_data_en   (i_ari_data_en[i]),
            .i_info      (i_ari_info[i]),
            .i_info_en   (i_ari_info_en[i]),
            .o_alf       (o_ari_fifo_alf[i]),
            .port        (port_bus[i])
        );
    end

    poll_grant #(
        .POLICY (POLICY)
    ) poll_grant_inst (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .ports       (port_bus),
        .i_take      (take),
        .o_valid     (grant_valid),
        .o_port      (grant_port)
    );

    poll_sender poll_sender_inst (
        .i_sys_clk      (i_sys_clk),
        .i_sys_rst_n    (i_sys_rst_n),
        .ports          (port_bus),
        .i_grant_valid  (grant_valid),
        .i_grant_port   (grant_port),
        .o_take         (take),
        .i_ari_fifo_alf (i_ari_fifo_alf),
        .o_ari_data     (o_ari_data),
        .o_ari_data_en  (o_ari_data_en),
        .o_ari_info     (o_ari_info),
        .o_ari_info_en  (o_ari_info_en)
    );

endmodule

`default_nettype wire

// ==== verilog/poll_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module poll_sender (
    input  wire                 i_sys_clk,
    input  wire                 i_sys_rst_n,
    ari_port_if.reader          ports [poll_pkg::NUM_PORTS],
    input  wire                 i_grant_valid,
    input  wire  [1:0]          i_grant_port,
    output logic                o_take,
    input  wire                 i_ari_fifo_alf,
    output ari_pkg::ari_beat_t  o_ari_data,
    output logic                o_ari_data_en,
    output ari_pkg::ari_info_t  o_ari_info,
    output logic                o_ari_info_en
);

    localparam int NP = poll_pkg::NUM_PORTS;

    poll_pkg::poll_state_e state;
    logic [1:0]            sel_port;            // port being drained
    ari_pkg::ari_beat_t    beat_arr [NP];
    ari_pkg::ari_info_t    info_arr [NP];
    ari_pkg::ari_beat_t    sel_beat;
    ari_pkg::ari_info_t    sel_info;
    logic                  sending;
    logic                  sel_tail;

    assign sending = (state == poll_pkg::ST_SEND);

    for (genvar i = 0; i < NP; i++) begin : g_port
        assign beat_arr[i]      = ports[i].beat;
        assign info_arr[i]      = ports[i].info;
        assign ports[i].data_rd = sending && (sel_port == 2'(i));   // one beat per cycle
        assign ports[i].info_rd = sending && (sel_port == 2'(i)) && sel_tail;
    end

    assign sel_beat = beat_arr[sel_port];
    assign sel_info = info_arr[sel_port];
    assign sel_tail = sel_beat.pos inside {ari_pkg::POS_TAIL, ari_pkg::POS_SINGLE};

    // downstream almost-full only blocks new frames
    assign o_take = (state == poll_pkg::ST_IDLE) && i_grant_valid && !i_ari_fifo_alf;

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            state    <= poll_pkg::ST_IDLE;
            sel_port <= '0;
        end else begin
            case (state)
                poll_pkg::ST_IDLE: begin
                    if (o_take) begin
                        sel_port <= i_grant_port;
                        state    <= poll_pkg::ST_SEND;
                    end
                end
                poll_pkg::ST_SEND: begin
                    if (sel_tail) begin
                        state <= poll_pkg::ST_IDLE;   // always idle between frames
                    end
                end
                default: state <= poll_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            o_ari_data    <= '0;
            o_ari_data_en <= 1'b0;
            o_ari_info    <= '0;
            o_ari_info_en <= 1'b0;
        end else begin
            o_ari_data_en <= sending;
            o_ari_info_en <= sending && sel_tail;       // lines up with tail beat
            if (sending) begin
                o_ari_data <= sel_beat;
            end
            if (sending && sel_tail) begin
                o_ari_info <= sel_info;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/poll_grant.sv ====
`timescale 1ns/1ps
`default_nettype none

module poll_grant #(
    parameter poll_pkg::poll_policy_e POLICY = poll_pkg::POLICY_RR
) (
    input  wire         i_sys_clk,
    input  wire         i_sys_rst_n,
    ari_port_if.watch   ports [poll_pkg::NUM_PORTS],
    input  wire         i_take,
    output logic        o_valid,
    output logic [1:0]  o_port
);

    localparam int NP = poll_pkg::NUM_PORTS;

    logic [NP-1:0] req;                         // ports with a whole frame
    logic [NP-1:0] mask;                        // recently served ports
    logic [NP-1:0] unmasked;
    logic [NP-1:0] cand;
    logic [NP-1:0] take_mask;

    for (genvar i = 0; i < NP; i++) begin : g_req
        assign req[i] = ~ports[i].info_empty;
    end

    assign unmasked = req & ~mask;

    always_comb begin
        if (POLICY == poll_pkg::POLICY_SP) begin
            cand = req;
        end else begin
            cand = (|unmasked) ? unmasked : req;   // wrap when all masked
        end
    end

    assign o_valid = |cand;

    // lowest index wins
    always_comb begin
        o_port = '0;
        for (int i = NP - 1; i >= 0; i--) begin
            if (cand[i]) begin
                o_port = 2'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NP; i++) begin
            take_mask[i] = (2'(i) <= o_port);      // chosen port and below
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            mask <= '0;
        end else if (i_take) begin
            mask <= take_mask;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ari_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module ari_ingress #(
    parameter int FIFO_DEPTH = 16,
    parameter int ALF_LEVEL  = 8
) (
    input  wire                 i_sys_clk,
    input  wire                 i_sys_rst_n,
    input  wire ari_pkg::ari_beat_t i_data,
    input  wire                 i_data_en,
    input  wire ari_pkg::ari_info_t i_info,
    input  wire                 i_info_en,
    output logic                o_alf,
    ari_port_if.buffer          port
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [CW-1:0] data_count;                  // beats held for this port

    sync_fifo #(
        .WIDTH (ari_pkg::BEAT_W),
        .DEPTH (FIFO_DEPTH)
    ) data_fifo_inst (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_wr        (i_data_en),
        .i_din       (i_data),
        .i_rd        (port.data_rd),
        .o_dout      (port.beat),
        .o_empty     (),
        .o_count     (data_count)
    );

    // one word per finished frame
    sync_fifo #(
        .WIDTH (ari_pkg::INFO_W),
        .DEPTH (FIFO_DEPTH)
    ) info_fifo_inst (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_wr        (i_info_en),
        .i_din       (i_info),
        .i_rd        (port.info_rd),
        .o_dout      (port.info),
        .o_empty     (port.info_empty),
        .o_count     ()
    );

    assign o_alf = (data_count >= CW'(ALF_LEVEL));   // upstream should hold off

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 36,
    parameter int DEPTH = 16
) (
    input  wire                           i_sys_clk,
    input  wire                           i_sys_rst_n,
    input  wire                           i_wr,
    input  wire  [WIDTH-1:0]              i_din,
    input  wire                           i_rd,
    output logic [WIDTH-1:0]              o_dout,
    output logic                          o_empty,
    output logic [$clog2(DEPTH+1)-1:0]    o_count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en   = i_wr && (count != CW'(DEPTH));    // drop writes when full
    assign rd_en   = i_rd && (count != '0);
    assign o_dout  = mem[rd_ptr];                      // first word fall through
    assign o_empty = (count == '0);
    assign o_count = count;

    always_ff @(posedge i_sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
        if (!i_sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ari_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ari_port_if;

    ari_pkg::ari_beat_t beat;                   // head of data fifo
    ari_pkg::ari_info_t info;                   // head of info fifo
    logic               info_empty;             // no complete frame buffered
    logic               data_rd;                // pop one beat
    logic               info_rd;                // pop one info word

    modport buffer (
        output beat,
        output info,
        output info_empty,
        input  data_rd,
        input  info_rd
    );

    modport reader (
        input  beat,
        input  info,
        output data_rd,
        output info_rd
    );

    // grant only needs to know which ports hold a frame
    modport watch (
        input  info_empty
    );

endinterface

`default_nettype wire

// ==== verilog/poll_pkg.sv ====
`default_nettype none

package poll_pkg;

    localparam int NUM_PORTS = 4;

    typedef enum logic {
        POLICY_RR = 1'b0,                       // masked round robin
        POLICY_SP = 1'b1                        // fixed priority, port 0 first
    } poll_policy_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_SEND = 1'b1
    } poll_state_e;

endpackage

`default_nettype wire

// ==== verilog/ari_pkg.sv ====
`default_nettype none

package ari_pkg;

    localparam int BEAT_W = 36;                 // pos + empty_bytes + payload
    localparam int INFO_W = 16;                 // valid + inport_bm + pkt_len

    // low bit set means the beat closes its frame
    typedef enum logic [1:0] {
        POS_BODY   = 2'b00,
        POS_TAIL   = 2'b01,
        POS_HEAD   = 2'b10,
        POS_SINGLE = 2'b11
    } frame_pos_e;

    typedef struct packed {
        frame_pos_e  pos;                       // place in frame
        logic [1:0]  empty_bytes;               // unused bytes of last beat
        logic [31:0] payload;
    } ari_beat_t;

    typedef struct packed {
        logic        valid;                     // frame good
        logic [3:0]  inport_bm;                 // source port bitmap
        logic [10:0] pkt_len;                   // length in bytes
    } ari_info_t;

endpackage

`default_nettype wire
